// ==== design/spwRxPkg.sv ====
package spwRxPkg;

	// Width of one bit pair handed from the line decoder to the character decoder.
	localparam int pairWidth = 2;

	// Width of a data byte and of a time code.
	localparam int charWidth = 8;

	// Character decoder states. The decoder opens each character in waitIct.
	typedef enum logic [2:0] {
		waitIct, // Parity bit and control flag expected.
		waitCmd, // Two control-code bits expected.
		waitP0, // Data bits 1:0 expected.
		waitP1, // Data bits 3:2 expected.
		waitP2, // Data bits 5:4 expected.
		waitP3 // Data bits 7:6 expected.
	} charState_e;

	// Control codes as received, with the first bit on the line at index 0.
	typedef enum logic [1:0] {
		fct = 2'd0, // Flow control token.
		eop = 2'd1, // Normal end of packet.
		eep = 2'd2, // Error end of packet.
		esc = 2'd3 // Escape, which modifies the next character.
	} ctrlCode_e;

endpackage

// ==== design/spwDsDecoder.sv ====
`timescale 1ns/10ps

module spwDsDecoder #(
	parameter int disconnectCycles = 32
) (
	input logic rxClk,
	input logic reset,
	input logic dsData,
	input logic dsStrobe,
	output logic [spwRxPkg::pairWidth-1:0] pair,
	output logic pairValid,
	output logic disconnect
);
	localparam int countWidth = $clog2(disconnectCycles + 1);

	logic dataQ;
	logic strobeQ;
	logic prevXor;
	logic transition;
	logic halfFull;
	logic firstBit;
	logic started;
	logic [countWidth-1:0] silentCount;

	// Data XOR Strobe toggles once per bit on a DS encoded line.
	assign transition = (dataQ ^ strobeQ) != prevXor;

	always_ff @(posedge rxClk) begin
		if (reset) begin
			dataQ <= 1'b0; // The line idles at zero on both wires.
			strobeQ <= 1'b0;
			prevXor <= 1'b0;
		end else begin
			dataQ <= dsData;
			strobeQ <= dsStrobe;
			prevXor <= dataQ ^ strobeQ;
		end
	end

	always_ff @(posedge rxClk) begin
		if (reset) begin
			halfFull <= 1'b0; // The first bit after reset opens a pair.
			pairValid <= 1'b0;
		end else begin
			pairValid <= 1'b0;
			if (transition && !disconnect) begin
				pairValid <= halfFull;
				halfFull <= ~halfFull;
			end
		end
	end

	always_ff @(posedge rxClk) begin
		if (transition) begin
			if (halfFull) begin
				pair <= {dataQ, firstBit}; // Earlier bit lands at index 0.
			end else begin
				firstBit <= dataQ;
			end
		end
	end

	always_ff @(posedge rxClk) begin
		if (reset) begin
			started <= 1'b0;
			silentCount <= '0;
			disconnect <= 1'b0;
		end else if (transition) begin
			started <= 1'b1;
			silentCount <= '0;
		end else if (started && !disconnect) begin
			if (silentCount == countWidth'(disconnectCycles - 1)) begin
				disconnect <= 1'b1; // Held until reset.
			end else begin
				silentCount <= silentCount + 1'b1;
			end
		end
	end

endmodule

// ==== design/spwCharDecoder.sv ====
`timescale 1ns/10ps

module spwCharDecoder (
	input logic rxClk,
	input logic reset,
	input logic [spwRxPkg::pairWidth-1:0] pair,
	input logic pairValid,
	output logic [spwRxPkg::charWidth-1:0] charData,
	output logic dataChar,
	output logic ctrlChar,
	output logic parityError
);
	localparam int slotWidth = $clog2(spwRxPkg::charWidth / spwRxPkg::pairWidth);

	spwRxPkg::charState_e state;
	spwRxPkg::charState_e nextState;
	logic [slotWidth-1:0] slot;
	logic collectPair;
	logic zeroParity;
	logic parityFail;
	logic nextDataChar;
	logic nextCtrlChar;
	logic [spwRxPkg::pairWidth-1:0] parityPair;

	always_ff @(posedge rxClk) begin
		if (reset) begin
			state <= spwRxPkg::waitIct;
			dataChar <= 1'b0;
			ctrlChar <= 1'b0;
		end else begin
			state <= nextState;
			dataChar <= nextDataChar;
			ctrlChar <= nextCtrlChar;
		end
	end

	// Each pair goes to a fixed slot, so a control code always sits in bits 1:0.
	always_ff @(posedge rxClk) begin
		if (collectPair) begin
			charData[slot*spwRxPkg::pairWidth +: spwRxPkg::pairWidth] <= pair;
		end
	end

	// Running XOR of the bits after the flag, checked by the next opening pair.
	always_ff @(posedge rxClk) begin
		if (reset || zeroParity) begin
			parityPair <= '0;
		end else if (collectPair) begin
			parityPair <= parityPair ^ pair;
		end
	end

	always_ff @(posedge rxClk) begin
		if (reset) begin
			parityError <= 1'b0;
		end else if (parityFail) begin
			parityError <= 1'b1;
		end
	end

	always_comb begin
		nextState = state;
		slot = '0;
		collectPair = 1'b0;
		zeroParity = 1'b0;
		parityFail = 1'b0;
		nextDataChar = 1'b0;
		nextCtrlChar = 1'b0;
		if (pairValid) begin
			case (state)
				spwRxPkg::waitIct: begin
					if (pair[1]) begin // Control flag set.
						nextState = spwRxPkg::waitCmd;
					end else begin
						nextState = spwRxPkg::waitP0;
					end
					parityFail = ~(^(pair ^ parityPair)); // Odd parity over both chars.
					zeroParity = 1'b1;
				end
				spwRxPkg::waitCmd: begin
					collectPair = 1'b1;
					nextCtrlChar = 1'b1;
					nextState = spwRxPkg::waitIct;
				end
				spwRxPkg::waitP0: begin
					collectPair = 1'b1;
					nextState = spwRxPkg::waitP1;
				end
				spwRxPkg::waitP1: begin
					slot = slotWidth'(1);
					collectPair = 1'b1;
					nextState = spwRxPkg::waitP2;
				end
				spwRxPkg::waitP2: begin
					slot = slotWidth'(2);
					collectPair = 1'b1;
					nextState = spwRxPkg::waitP3;
				end
				spwRxPkg::waitP3: begin
					slot = slotWidth'(3);
					collectPair = 1'b1;
					nextDataChar = 1'b1;
					nextState = spwRxPkg::waitIct;
				end
				default: begin
					nextState = spwRxPkg::waitIct;
				end
			endcase
		end
	end

endmodule

// ==== design/spwCodeClassifier.sv ====
`timescale 1ns/10ps

module spwCodeClassifier (
	input logic rxClk,
	input logic reset,
	input logic [spwRxPkg::charWidth-1:0] charData,
	input logic dataChar,
	input logic ctrlChar,
	output logic [spwRxPkg::charWidth-1:0] rxData,
	output logic rxDataValid,
	output logic rxEop,
	output logic rxEep,
	output logic rxFct,
	output logic gotNull,
	output logic [spwRxPkg::charWidth-1:0] timeCode,
	output logic timeValid,
	output logic escError
);
	spwRxPkg::ctrlCode_e ctrlCode;
	logic escPending;

	assign ctrlCode = spwRxPkg::ctrlCode_e'(charData[spwRxPkg::pairWidth-1:0]);

	always_ff @(posedge rxClk) begin
		if (reset) begin
			rxDataValid <= 1'b0;
			rxEop <= 1'b0;
			rxEep <= 1'b0;
			rxFct <= 1'b0;
			gotNull <= 1'b0;
			timeValid <= 1'b0;
			escPending <= 1'b0;
			escError <= 1'b0;
		end else begin
			rxDataValid <= 1'b0;
			rxEop <= 1'b0;
			rxEep <= 1'b0;
			rxFct <= 1'b0;
			gotNull <= 1'b0;
			timeValid <= 1'b0;
			if (dataChar) begin
				if (escPending) begin
					timeValid <= 1'b1; // ESC plus a data character is a time code.
				end else begin
					rxDataValid <= 1'b1;
				end
				escPending <= 1'b0;
			end else if (ctrlChar) begin
				if (escPending) begin
					escPending <= 1'b0;
					if (ctrlCode == spwRxPkg::fct) begin
						gotNull <= 1'b1;
					end else begin
						escError <= 1'b1; // Both characters are dropped.
					end
				end else begin
					case (ctrlCode)
						spwRxPkg::fct: rxFct <= 1'b1;
						spwRxPkg::eop: rxEop <= 1'b1;
						spwRxPkg::eep: rxEep <= 1'b1;
						spwRxPkg::esc: escPending <= 1'b1;
						default: escPending <= 1'b0;
					endcase
				end
			end
		end
	end

	always_ff @(posedge rxClk) begin
		if (dataChar) begin
			if (escPending) begin
				timeCode <= charData;
			end else begin
				rxData <= charData;
			end
		end
	end

endmodule

// ==== design/spwRxTop.sv ====
`timescale 1ns/10ps

module spwRxTop #(
	parameter int disconnectCycles = 32
) (
	input logic rxClk,
	input logic reset,
	input logic dsData,
	input logic dsStrobe,
	output logic [spwRxPkg::charWidth-1:0] rxData,
	output logic rxDataValid,
	output logic rxEop,
	output logic rxEep,
	output logic rxFct,
	output logic gotNull,
	output logic [spwRxPkg::charWidth-1:0] timeCode,
	output logic timeValid,
	output logic parityError,
	output logic escError,
	output logic disconnect
);
	logic [spwRxPkg::pairWidth-1:0] pair;
	logic pairValid;
	logic [spwRxPkg::charWidth-1:0] charData;
	logic dataChar;
	logic ctrlChar;

	spwDsDecoder #(
		.disconnectCycles(disconnectCycles)
	) dsDecoder0 (
		.rxClk(rxClk),
		.reset(reset),
		.dsData(dsData),
		.dsStrobe(dsStrobe),
		.pair(pair),
		.pairValid(pairValid),
		.disconnect(disconnect)
	);

	spwCharDecoder charDecoder0 (
		.rxClk(rxClk),
		.reset(reset),
		.pair(pair),
		.pairValid(pairValid),
		.charData(charData),
		.dataChar(dataChar),
		.ctrlChar(ctrlChar),
		.parityError(parityError)
	);

	spwCodeClassifier codeClassifier0 (
		.rxClk(rxClk),
		.reset(reset),
		.charData(charData),
		.dataChar(dataChar),
		.ctrlChar(ctrlChar),
		.rxData(rxData),
		.rxDataValid(rxDataValid),
		.rxEop(rxEop),
		.rxEep(rxEep),
		.rxFct(rxFct),
		.gotNull(gotNull),
		.timeCode(timeCode),
		.timeValid(timeValid),
		.escError(escError)
	);

endmodule

// ==== sim/spwDsSource.sv ====
`timescale 1ns/10ps

module spwDsSource (
	input logic rxClk,
	output logic dsData,
	output logic dsStrobe
);
	logic lastXor; // XOR of the data or code bits of the last character.

	task automatic lineReset();
		dsData = 1'b0;
		dsStrobe = 1'b0;
		lastXor = 1'b0;
	endtask

	task automatic sendBit(input logic b);
		@(posedge rxClk);
		#1;
		if (b == dsData) begin
			dsStrobe = ~dsStrobe; // Strobe carries the edge when Data repeats.
		end else begin
			dsData = b;
		end
		repeat (3) @(posedge rxClk);
	endtask

	task automatic sendChar(input logic flag, input logic [7:0] bits, input int n,
			input logic flip);
		logic parity;
		logic bitsXor;
		parity = 1'b1 ^ lastXor ^ flag ^ flip; // Odd parity over the previous bits and the flag.
		bitsXor = 1'b0;
		sendBit(parity);
		sendBit(flag);
		for (int i = 0; i < n; i++) begin
			sendBit(bits[i]);
			bitsXor = bitsXor ^ bits[i];
		end
		lastXor = bitsXor;
	endtask

	task automatic sendData(input logic [7:0] value, input logic flip);
		sendChar(1'b0, value, 8, flip);
	endtask

	task automatic sendCtrl(input spwRxPkg::ctrlCode_e code, input logic flip);
		sendChar(1'b1, {6'b0, code}, 2, flip);
	endtask

endmodule

// ==== sim/spwRxTb.sv ====
`timescale 1ns/10ps

module spwRxTb;
	localparam int evData = 0;
	localparam int evEop = 1;
	localparam int evEep = 2;
	localparam int evFct = 3;
	localparam int evNull = 4;
	localparam int evTime = 5;
	// Bits on the line over all tests. A control character is 4 bits, a data character 10.
	localparam int totalBits = 24 + 164 + 22 + 38 + 8 + 30;
	localparam int timeoutCycles = totalBits * 4 * 2 + 200;

	logic rxClk;
	logic reset;
	logic dsData;
	logic dsStrobe;
	logic [spwRxPkg::charWidth-1:0] rxData;
	logic [spwRxPkg::charWidth-1:0] timeCode;
	logic rxDataValid;
	logic rxEop;
	logic rxEep;
	logic rxFct;
	logic gotNull;
	logic timeValid;
	logic parityError;
	logic escError;
	logic disconnect;
	integer seed;
	int errorCount;
	int passCount;
	int failCount;
	int cycleCount;
	int evKind[$];
	logic [spwRxPkg::charWidth-1:0] evValue[$];

	spwRxTop #(
		.disconnectCycles(32)
	) dut0 (
		.rxClk(rxClk),
		.reset(reset),
		.dsData(dsData),
		.dsStrobe(dsStrobe),
		.rxData(rxData),
		.rxDataValid(rxDataValid),
		.rxEop(rxEop),
		.rxEep(rxEep),
		.rxFct(rxFct),
		.gotNull(gotNull),
		.timeCode(timeCode),
		.timeValid(timeValid),
		.parityError(parityError),
		.escError(escError),
		.disconnect(disconnect)
	);

	spwDsSource src0 (
		.rxClk(rxClk),
		.dsData(dsData),
		.dsStrobe(dsStrobe)
	);

	initial begin
		rxClk = 1'b0;
		forever #50 rxClk = ~rxClk;
	end

	task automatic logEvent(input int kind, input logic [spwRxPkg::charWidth-1:0] value);
		evKind.push_back(kind);
		evValue.push_back(value);
	endtask

	// Strobes are registered on the rising edge, so the falling edge sees them settled.
	always @(negedge rxClk) begin
		if (rxDataValid) logEvent(evData, rxData);
		if (rxEop) logEvent(evEop, 8'h00);
		if (rxEep) logEvent(evEep, 8'h00);
		if (rxFct) logEvent(evFct, 8'h00);
		if (gotNull) logEvent(evNull, 8'h00);
		if (timeValid) logEvent(evTime, timeCode);
	end

	always @(posedge rxClk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("Run stopped by timeout after %0d cycles.", cycleCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic checkByte(input string name, input logic [spwRxPkg::charWidth-1:0] got,
			input logic [spwRxPkg::charWidth-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic expectEvent(input int kind, input string name,
			input logic [spwRxPkg::charWidth-1:0] value);
		int gotKind;
		logic [spwRxPkg::charWidth-1:0] gotValue;
		if (evKind.size() == 0) begin
			$display("Missing %s strobe.", name);
			errorCount++;
		end else begin
			gotKind = evKind.pop_front();
			gotValue = evValue.pop_front();
			if (gotKind != kind) begin
				$display("Expected a %s strobe but a different strobe came first.", name);
				errorCount++;
			end else if (kind == evData || kind == evTime) begin
				checkByte(name, gotValue, value); // Only data and time codes carry a byte.
			end
		end
	endtask

	task automatic expectQuiet();
		if (evKind.size() != 0) begin
			$display("Saw %0d unexpected output strobes.", evKind.size());
			errorCount++;
		end
	endtask

	task automatic waitEvents(input int n);
		int waited;
		waited = 0;
		while (evKind.size() < n && waited < 40) begin
			@(negedge rxClk);
			waited++;
		end
		repeat (8) @(negedge rxClk); // Lets any extra strobe show up.
	endtask

	task automatic resetDut();
		@(posedge rxClk);
		#1;
		reset = 1'b1;
		src0.lineReset();
		repeat (10) @(posedge rxClk);
		#1;
		reset = 1'b0;
		evKind.delete();
		evValue.delete();
	endtask

	task automatic endTest(input string name, input int startErrors);
		if (errorCount == startErrors) begin
			passCount++;
			$display("%s: ok", name);
		end else begin
			failCount++;
			$display("%s: %0d errors", name, errorCount - startErrors);
		end
	endtask

	task automatic testNullStart();
		int startErrors;
		startErrors = errorCount;
		resetDut();
		repeat (3) begin
			src0.sendCtrl(spwRxPkg::esc, 1'b0);
			src0.sendCtrl(spwRxPkg::fct, 1'b0);
		end
		waitEvents(3);
		repeat (3) expectEvent(evNull, "gotNull", 8'h00);
		expectQuiet();
		checkFlag("parityError", parityError, 1'b0);
		endTest("testNullStart", startErrors);
	endtask

	task automatic testDataStream();
		int startErrors;
		logic [spwRxPkg::charWidth-1:0] sent[16];
		startErrors = errorCount;
		resetDut();
		for (int i = 0; i < 16; i++) begin
			sent[i] = 8'($random(seed));
			src0.sendData(sent[i], 1'b0);
		end
		src0.sendCtrl(spwRxPkg::eop, 1'b0);
		waitEvents(17);
		for (int i = 0; i < 16; i++) begin
			expectEvent(evData, "rxData", sent[i]);
		end
		expectEvent(evEop, "rxEop", 8'h00);
		expectQuiet();
		checkFlag("parityError", parityError, 1'b0);
		endTest("testDataStream", startErrors);
	endtask

	task automatic testControlAndTime();
		int startErrors;
		logic [spwRxPkg::charWidth-1:0] tick;
		startErrors = errorCount;
		resetDut();
		tick = 8'($random(seed));
		src0.sendCtrl(spwRxPkg::fct, 1'b0);
		src0.sendCtrl(spwRxPkg::eep, 1'b0);
		src0.sendCtrl(spwRxPkg::esc, 1'b0);
		src0.sendData(tick, 1'b0);
		waitEvents(3);
		expectEvent(evFct, "rxFct", 8'h00);
		expectEvent(evEep, "rxEep", 8'h00);
		expectEvent(evTime, "timeCode", tick);
		expectQuiet(); // The time byte must not appear on rxData.
		endTest("testControlAndTime", startErrors);
	endtask

	task automatic testParityError();
		int startErrors;
		startErrors = errorCount;
		resetDut();
		src0.sendCtrl(spwRxPkg::fct, 1'b0);
		src0.sendData(8'($random(seed)), 1'b0);
		waitEvents(2);
		checkFlag("parityError", parityError, 1'b0);
		src0.sendData(8'($random(seed)), 1'b1);
		waitEvents(3);
		checkFlag("parityError", parityError, 1'b1);
		src0.sendData(8'($random(seed)), 1'b0);
		src0.sendCtrl(spwRxPkg::fct, 1'b0);
		waitEvents(5);
		checkFlag("parityError", parityError, 1'b1); // Sticky until reset.
		endTest("testParityError", startErrors);
	endtask

	task automatic testEscError();
		int startErrors;
		int waited;
		startErrors = errorCount;
		resetDut();
		src0.sendCtrl(spwRxPkg::esc, 1'b0);
		src0.sendCtrl(spwRxPkg::eop, 1'b0);
		waited = 0;
		while (!escError && waited < 40) begin
			@(negedge rxClk);
			waited++;
		end
		repeat (4) @(negedge rxClk);
		checkFlag("escError", escError, 1'b1);
		expectQuiet();
		endTest("testEscError", startErrors);
	endtask

	task automatic testDisconnect();
		int startErrors;
		int waited;
		startErrors = errorCount;
		resetDut();
		src0.sendData(8'h5a, 1'b0);
		src0.sendData(8'ha5, 1'b0);
		@(negedge rxClk);
		checkFlag("disconnect", disconnect, 1'b0);
		waited = 0;
		while (!disconnect && waited < 36) begin // The last edge was about 4 cycles ago.
			@(negedge rxClk);
			waited++;
		end
		checkFlag("disconnect", disconnect, 1'b1);
		expectEvent(evData, "rxData", 8'h5a);
		expectEvent(evData, "rxData", 8'ha5);
		src0.sendData(8'($random(seed)), 1'b0);
		repeat (12) @(negedge rxClk);
		expectQuiet();
		endTest("testDisconnect", startErrors);
	endtask

	initial begin
		reset = 1'b1;
		src0.lineReset();
		seed = 32'h9256302f;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		cycleCount = 0;
		testNullStart();
		testDataStream();
		testControlAndTime();
		testParityError();
		testEscError();
		testDisconnect();
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
design/spwRxPkg.sv
design/spwDsDecoder.sv
design/spwCharDecoder.sv
design/spwCodeClassifier.sv
design/spwRxTop.sv
sim/spwDsSource.sv
sim/spwRxTb.sv

// ==== Bender.yml ====
package:
  name: spw_rx

sources:
  - design/spwRxPkg.sv
  - design/spwDsDecoder.sv
  - design/spwCharDecoder.sv
  - design/spwCodeClassifier.sv
  - design/spwRxTop.sv
  - target: simulation
    files:
      - sim/spwDsSource.sv
      - sim/spwRxTb.sv
